//--- list.f
verilog/rob_pkg.sv
verilog/rob_ctrl.sv
verilog/rob_info_store.sv
verilog/rob_result_store.sv
verilog/rob_top.sv
tb/rob_assertions.sv
tb/tb_rob.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       := tb_rob
FILELIST  := list.f
BUILD     := obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

//--- tb/tb_rob.sv
`default_nettype none
`timescale 1ns/10ps

module tb_rob;

  localparam int DEPTH = rob_pkg::rob_depth_default;
  localparam int IDX_W = $clog2(DEPTH);
  localparam int NDP = rob_pkg::num_dp_default;
  localparam int NRT = rob_pkg::num_rt_default;
  localparam int NPU = rob_pkg::num_pu_default;
  localparam int DW = rob_pkg::data_width_default;
  localparam int VW = rob_pkg::vreg_idx_width;
  localparam int PERIOD = 40;
  localparam int TEST_CYCLES = 1200;
  localparam int TIMEOUT_NS = (TEST_CYCLES + 100) * PERIOD;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic [NDP-1:0] uop_valid = '0;
  logic [NDP-1:0][VW-1:0] uop_w_index = '0;
  logic [NDP-1:0] uop_last = '0;
  logic [NPU-1:0] res_valid = '0;
  logic [NPU-1:0][IDX_W-1:0] res_entry = '0;
  logic [NPU-1:0] res_w_valid = '0;
  logic [NPU-1:0][DW-1:0] res_data = '0;
  logic [NPU-1:0] res_vxsat = '0;
  logic trap_valid = 1'b0;
  logic [IDX_W-1:0] trap_entry = '0;
  logic [NRT-1:0] rt_ready = '0;
  wire [NDP-1:0] uop_ready;
  wire [IDX_W-1:0] uop_index;
  wire [NRT-1:0] rt_valid;
  wire [NRT-1:0] rt_w_valid;
  wire [NRT-1:0][VW-1:0] rt_w_index;
  wire [NRT-1:0][DW-1:0] rt_data;
  wire [NRT-1:0] rt_vxsat;
  wire [NRT-1:0] rt_trap;
  wire [NRT-1:0] rt_last;
  wire [DEPTH-1:0] dp_entry_valid;
  wire [DEPTH-1:0] dp_w_valid;
  wire [DEPTH-1:0][VW-1:0] dp_w_index;
  wire [DEPTH-1:0][DW-1:0] dp_data;

  // model of the buffer, entry indices in program order
  logic [IDX_W-1:0] order_q[$];
  logic m_live [DEPTH] = '{default: 1'b0};
  logic m_done [DEPTH] = '{default: 1'b0};
  logic m_trap [DEPTH] = '{default: 1'b0};
  logic m_wv [DEPTH];
  logic m_last [DEPTH];
  logic m_vx [DEPTH];
  logic [VW-1:0] m_widx [DEPTH];
  logic [DW-1:0] m_data [DEPTH];
  logic [IDX_W-1:0] exp_wptr = '0;

  // phase controls
  int push_mode = 0;
  int rdy_mode = 0;
  logic res_on = 1'b0;
  logic trap_on = 1'b0;
  logic fill_on = 1'b0;

  logic [31:0] lcg_state = 32'd61;
  int chk_errors = 0;
  int seq_errors = 0;
  int fill_cnt = 0;
  int hold_cycles = 0;
  int flush_cnt = 0;
  int traps_sent = 0;
  logic held = 1'b0;
  logic [VW-1:0] held_widx;
  logic [DW-1:0] held_data;

  rob_top i_dut (.*);

  always #(PERIOD / 2) clk = ~clk;

  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // retire lanes as the in-order rules give them
  function automatic void expected_retire(
    output logic [NRT-1:0] valid,
    output logic [NRT-1:0] trap,
    output logic [NRT-1:0] w_valid,
    output logic [NRT-1:0][VW-1:0] w_index,
    output logic [NRT-1:0][DW-1:0] data,
    output logic [NRT-1:0] last,
    output logic [NRT-1:0] vxsat
  );
    logic chain;
    logic [IDX_W-1:0] e;
    chain = 1'b1;
    valid = '0;
    trap = '0;
    w_valid = '0;
    w_index = '0;
    data = '0;
    last = '0;
    vxsat = '0;
    for (int k = 0; k < NRT; k++) begin
      if (k < order_q.size()) begin
        e = order_q[k];
        valid[k] = chain & m_done[e];
        trap[k] = m_trap[e];
        w_valid[k] = m_wv[e] & valid[k];
        w_index[k] = m_widx[e];
        data[k] = m_data[e];
        last[k] = m_last[e];
        vxsat[k] = m_vx[e];
        chain = valid[k] & ~m_trap[e];
      end
    end
  endfunction

  task automatic report_mismatch(input string what, input logic [DW-1:0] got,
                                 input logic [DW-1:0] exp);
    chk_errors++;
    $display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
  endtask

  task automatic settle_cycle();
    @(negedge clk);
    #1;
  endtask

  // stimulus, driven on the rising edge
  always @(posedge clk) begin : drive
    logic [DEPTH-1:0] used;
    logic [IDX_W-1:0] e;
    int n;
    int pos;
    if (rst_n) begin
      n = 0;
      if (push_mode == 1) n = rand16() % 3;
      if (push_mode == 2) n = 1 + rand16() % 2;
      uop_valid <= NDP'((1 << n) - 1);
      for (int k = 0; k < NDP; k++) begin
        uop_w_index[k] <= VW'(rand16());
        uop_last[k] <= 1'(rand16() & 1);
      end
      n = rdy_mode == 2 ? NRT : (rdy_mode == 1 ? rand16() % 3 : 0);
      rt_ready <= NRT'((1 << n) - 1);
      // results only on pending entries, one port per entry
      used = '0;
      for (int p = 0; p < NPU; p++) begin
        res_valid[p] <= 1'b0;
        if (res_on && order_q.size() > 0 && rand16() % 4 != 0) begin
          pos = rand16() % order_q.size();
          e = order_q[pos];
          if (!m_done[e] && !used[e]) begin
            used[e] = 1'b1;
            res_valid[p] <= 1'b1;
            res_entry[p] <= e;
            res_w_valid[p] <= 1'(rand16() & 1);
            res_data[p] <= {rand16(), rand16()};
            res_vxsat[p] <= 1'(rand16() & 1);
          end
        end
      end
      // one trap outstanding, never on the oldest uop
      trap_valid <= 1'b0;
      if (trap_on && traps_sent == flush_cnt && order_q.size() > 1) begin
        pos = 1 + rand16() % (order_q.size() - 1);
        e = order_q[pos];
        if (!m_done[e]) begin
          trap_valid <= 1'b1;
          trap_entry <= e;
          traps_sent++;
        end
      end
    end
  end

  // compare at the falling edge, then advance the model past the next rising edge
  always @(negedge clk) begin : compare
    logic [NRT-1:0] e_valid;
    logic [NRT-1:0] e_trap;
    logic [NRT-1:0] e_wv;
    logic [NRT-1:0][VW-1:0] e_widx;
    logic [NRT-1:0][DW-1:0] e_data;
    logic [NRT-1:0] e_last;
    logic [NRT-1:0] e_vx;
    logic [NDP-1:0] acc;
    logic [IDX_W-1:0] e;
    logic flush;
    int occ;
    int n_pop;
    if (rst_n) begin
      occ = order_q.size();
      if (uop_ready[0] !== (occ < DEPTH)) begin
        report_mismatch("uop_ready[0]", uop_ready[0], occ < DEPTH);
      end
      if (uop_ready[1] !== (occ < DEPTH - 1)) begin
        report_mismatch("uop_ready[1]", uop_ready[1], occ < DEPTH - 1);
      end
      if (uop_index !== exp_wptr) report_mismatch("uop_index", uop_index, exp_wptr);
      for (int a = 0; a < DEPTH; a++) begin
        if (a < occ) begin
          e = order_q[a];
          if (dp_entry_valid[a] !== 1'b1) report_mismatch("dp_entry_valid", dp_entry_valid[a], 1);
          if (dp_w_index[a] !== m_widx[e]) report_mismatch("dp_w_index", dp_w_index[a], m_widx[e]);
          if (dp_w_valid[a] !== (m_done[e] & m_wv[e])) begin
            report_mismatch("dp_w_valid", dp_w_valid[a], m_done[e] & m_wv[e]);
          end
          if (m_done[e] && dp_data[a] !== m_data[e]) begin
            report_mismatch("dp_data", dp_data[a], m_data[e]);
          end
        end else if (dp_entry_valid[a] !== 1'b0) begin
          report_mismatch("dp_entry_valid", dp_entry_valid[a], 0);
        end
      end
      expected_retire(e_valid, e_trap, e_wv, e_widx, e_data, e_last, e_vx);
      if (rt_valid !== e_valid) report_mismatch("rt_valid", rt_valid, e_valid);
      if (rt_w_valid !== e_wv) report_mismatch("rt_w_valid", rt_w_valid, e_wv);
      for (int k = 0; k < NRT; k++) begin
        if (e_valid[k]) begin
          if (rt_w_index[k] !== e_widx[k]) report_mismatch("rt_w_index", rt_w_index[k], e_widx[k]);
          if (rt_data[k] !== e_data[k]) report_mismatch("rt_data", rt_data[k], e_data[k]);
          if (rt_last[k] !== e_last[k]) report_mismatch("rt_last", rt_last[k], e_last[k]);
          if (rt_vxsat[k] !== e_vx[k]) report_mismatch("rt_vxsat", rt_vxsat[k], e_vx[k]);
          if (rt_trap[k] !== e_trap[k]) report_mismatch("rt_trap", rt_trap[k], e_trap[k]);
        end
      end
      // lane 0 must not move while the retire unit stalls
      if (held) begin
        if (rt_valid[0] !== 1'b1) report_mismatch("held rt_valid[0]", rt_valid[0], 1);
        if (rt_data[0] !== held_data) report_mismatch("held rt_data[0]", rt_data[0], held_data);
        if (rt_w_index[0] !== held_widx) begin
          report_mismatch("held rt_w_index[0]", rt_w_index[0], held_widx);
        end
      end
      held = e_valid[0] && rt_ready == '0;
      held_data = e_data[0];
      held_widx = e_widx[0];
      if (held) hold_cycles++;
      // uops the DUT takes by handshake while the fill runs
      if (fill_on) begin
        for (int k = 0; k < NDP; k++) begin
          if (uop_valid[k] && uop_ready[k]) fill_cnt++;
        end
      end
      // results and traps only land on entries live before the edge
      for (int p = 0; p < NPU; p++) begin
        if (res_valid[p] && m_live[res_entry[p]]) begin
          m_done[res_entry[p]] = 1'b1;
          m_wv[res_entry[p]] = res_w_valid[p];
          m_data[res_entry[p]] = res_data[p];
          m_vx[res_entry[p]] = res_vxsat[p];
        end
      end
      if (trap_valid && m_live[trap_entry]) m_trap[trap_entry] = 1'b1;
      n_pop = 0;
      flush = 1'b0;
      for (int k = 0; k < NRT; k++) begin
        if (e_valid[k] && rt_ready[k]) begin
          n_pop++;
          flush = flush | e_trap[k];
        end
      end
      for (int k = 0; k < n_pop; k++) begin
        e = order_q.pop_front();
        m_live[e] = 1'b0;
      end
      if (flush) begin
        foreach (order_q[i]) m_live[order_q[i]] = 1'b0;
        order_q.delete();
        flush_cnt++;
      end else begin
        for (int k = 0; k < NDP; k++) begin
          acc[k] = uop_valid[k] && occ + k < DEPTH && (k == 0 || acc[k-1]);
          if (acc[k]) begin
            e = exp_wptr + IDX_W'(k);
            m_live[e] = 1'b1;
            m_done[e] = 1'b0;
            m_trap[e] = 1'b0;
            m_widx[e] = uop_w_index[k];
            m_last[e] = uop_last[k];
            order_q.push_back(e);
          end
        end
        exp_wptr = exp_wptr + IDX_W'(order_q.size() - (occ - n_pop));
      end
    end
  end

  initial begin
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    settle_cycle();
    if (uop_ready !== '1 || uop_index !== '0 || rt_valid !== '0 || dp_entry_valid !== '0) begin
      seq_errors++;
      $display("Mismatch at %0d ns: state after reset ready %b index %0d rt_valid %b view %b",
               $time, uop_ready, uop_index, rt_valid, dp_entry_valid);
    end
    // random traffic
    push_mode = 1;
    rdy_mode = 1;
    res_on = 1'b1;
    repeat (400) settle_cycle();
    // drain, then fill with the retire unit stalled
    push_mode = 0;
    rdy_mode = 2;
    while (order_q.size() != 0) settle_cycle();
    push_mode = 2;
    rdy_mode = 0;
    fill_on = 1'b1;
    repeat (30) settle_cycle();
    fill_on = 1'b0;
    if (fill_cnt != DEPTH) begin
      seq_errors++;
      $display("Mismatch at %0d ns: %0d uops accepted into an empty buffer, expected %0d",
               $time, fill_cnt, DEPTH);
    end
    if (hold_cycles == 0) begin
      seq_errors++;
      $display("retire lane was never held with a done uop");
    end
    // traps on pending uops
    push_mode = 1;
    rdy_mode = 1;
    trap_on = 1'b1;
    while (flush_cnt < 3) settle_cycle();
    trap_on = 1'b0;
    push_mode = 0;
    rdy_mode = 2;
    while (order_q.size() != 0) settle_cycle();
    repeat (2) settle_cycle();
    $display("errors: %0d mismatches, %0d sequence failures", chk_errors, seq_errors);
    if (chk_errors + seq_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run still going after %0d ns", TIMEOUT_NS);
    $display("errors: %0d mismatches, %0d sequence failures", chk_errors, seq_errors);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/rob_assertions.sv
`default_nettype none
`timescale 1ns/10ps

module rob_assertions #(
  parameter int ROB_DEPTH = rob_pkg::rob_depth_default,
  parameter int NUM_RT = rob_pkg::num_rt_default,
  parameter int NUM_PU = rob_pkg::num_pu_default,
  localparam int IDX_W = $clog2(ROB_DEPTH)
) (
  input wire clk,
  input wire rst_n,
  input wire [NUM_RT-1:0] rt_valid,
  input wire [NUM_RT-1:0] rt_ready,
  input wire [NUM_RT-1:0] rt_trap,
  input wire [NUM_PU-1:0] res_we,
  input wire [NUM_PU-1:0][IDX_W-1:0] res_entry,
  input wire [IDX_W:0] count
);

  // retire valids form a prefix
  for (genvar k = 1; k < NUM_RT; k++) begin : g_prefix
    a_prefix: assert property (@(posedge clk) disable iff (!rst_n)
      rt_valid[k] |-> rt_valid[k-1])
      else $error("retire lane %0d valid while lane %0d is not", k, k - 1);
  end

  // no two result ports on one entry
  for (genvar p = 0; p < NUM_PU; p++) begin : g_pu
    for (genvar r = p + 1; r < NUM_PU; r++) begin : g_pair
      a_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        !(res_we[p] && res_we[r] && res_entry[p] == res_entry[r]))
        else $error("result ports %0d and %0d write the same entry", p, r);
    end
  end

  a_flush: assert property (@(posedge clk) disable iff (!rst_n)
    |(rt_valid & rt_ready & rt_trap) |=> count == '0)
    else $error("buffer not empty after a trapped uop retired");

  a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
    count <= (IDX_W + 1)'(ROB_DEPTH))
    else $error("occupancy above the buffer depth");

endmodule

bind rob_ctrl rob_assertions #(
  .ROB_DEPTH (ROB_DEPTH),
  .NUM_RT    (NUM_RT),
  .NUM_PU    (NUM_PU)
) i_assertions (
  .clk       (clk),
  .rst_n     (rst_n),
  .rt_valid  (rt_valid),
  .rt_ready  (rt_ready),
  .rt_trap   (rt_trap),
  .res_we    (res_we),
  .res_entry (res_entry),
  .count     (count)
);

`default_nettype wire

//--- verilog/rob_top.sv
`default_nettype none
`timescale 1ns/10ps

module rob_top #(
  parameter int ROB_DEPTH = rob_pkg::rob_depth_default,
  parameter int NUM_DP = rob_pkg::num_dp_default,
  parameter int NUM_RT = rob_pkg::num_rt_default,
  parameter int NUM_PU = rob_pkg::num_pu_default,
  parameter int DATA_WIDTH = rob_pkg::data_width_default,
  localparam int IDX_W = $clog2(ROB_DEPTH),
  localparam int VW = rob_pkg::vreg_idx_width
) (
  input wire clk,
  input wire rst_n,
  // dispatch
  input wire [NUM_DP-1:0] uop_valid,
  input wire [NUM_DP-1:0][VW-1:0] uop_w_index,
  input wire [NUM_DP-1:0] uop_last,
  output logic [NUM_DP-1:0] uop_ready,
  output logic [IDX_W-1:0] uop_index,
  // processing unit results, always accepted
  input wire [NUM_PU-1:0] res_valid,
  input wire [NUM_PU-1:0][IDX_W-1:0] res_entry,
  input wire [NUM_PU-1:0] res_w_valid,
  input wire [NUM_PU-1:0][DATA_WIDTH-1:0] res_data,
  input wire [NUM_PU-1:0] res_vxsat,
  // trap, always accepted
  input wire trap_valid,
  input wire [IDX_W-1:0] trap_entry,
  // retire
  output logic [NUM_RT-1:0] rt_valid,
  output logic [NUM_RT-1:0] rt_w_valid,
  output logic [NUM_RT-1:0][VW-1:0] rt_w_index,
  output logic [NUM_RT-1:0][DATA_WIDTH-1:0] rt_data,
  output logic [NUM_RT-1:0] rt_vxsat,
  output logic [NUM_RT-1:0] rt_trap,
  output logic [NUM_RT-1:0] rt_last,
  input wire [NUM_RT-1:0] rt_ready,
  // dispatch view, age 0 is the oldest
  output logic [ROB_DEPTH-1:0] dp_entry_valid,
  output logic [ROB_DEPTH-1:0] dp_w_valid,
  output logic [ROB_DEPTH-1:0][VW-1:0] dp_w_index,
  output logic [ROB_DEPTH-1:0][DATA_WIDTH-1:0] dp_data
);

  logic [NUM_DP-1:0] push_en;
  logic [IDX_W-1:0] wptr;
  logic [IDX_W-1:0] rptr;
  logic [NUM_PU-1:0] res_we;
  logic [ROB_DEPTH-1:0] dp_done;

  rob_ctrl #(
    .ROB_DEPTH (ROB_DEPTH),
    .NUM_DP    (NUM_DP),
    .NUM_RT    (NUM_RT),
    .NUM_PU    (NUM_PU)
  ) i_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .uop_valid      (uop_valid),
    .uop_ready      (uop_ready),
    .uop_index      (uop_index),
    .res_valid      (res_valid),
    .res_entry      (res_entry),
    .trap_valid     (trap_valid),
    .trap_entry     (trap_entry),
    .rt_ready       (rt_ready),
    .rt_valid       (rt_valid),
    .rt_trap        (rt_trap),
    .push_en        (push_en),
    .wptr           (wptr),
    .rptr           (rptr),
    .res_we         (res_we),
    .dp_entry_valid (dp_entry_valid),
    .dp_done        (dp_done)
  );

  rob_info_store #(
    .ROB_DEPTH (ROB_DEPTH),
    .NUM_DP    (NUM_DP),
    .NUM_RT    (NUM_RT)
  ) i_info (
    .clk         (clk),
    .push_en     (push_en),
    .wptr        (wptr),
    .uop_w_index (uop_w_index),
    .uop_last    (uop_last),
    .rptr        (rptr),
    .rt_w_index  (rt_w_index),
    .rt_last     (rt_last),
    .dp_w_index  (dp_w_index)
  );

  rob_result_store #(
    .ROB_DEPTH  (ROB_DEPTH),
    .NUM_RT     (NUM_RT),
    .NUM_PU     (NUM_PU),
    .DATA_WIDTH (DATA_WIDTH)
  ) i_result (
    .clk         (clk),
    .res_we      (res_we),
    .res_entry   (res_entry),
    .res_w_valid (res_w_valid),
    .res_data    (res_data),
    .res_vxsat   (res_vxsat),
    .rptr        (rptr),
    .rt_valid    (rt_valid),
    .dp_done     (dp_done),
    .rt_w_valid  (rt_w_valid),
    .rt_data     (rt_data),
    .rt_vxsat    (rt_vxsat),
    .dp_w_valid  (dp_w_valid),
    .dp_data     (dp_data)
  );

endmodule

`default_nettype wire

//--- verilog/rob_result_store.sv
`default_nettype none
`timescale 1ns/10ps

module rob_result_store #(
  parameter int ROB_DEPTH = rob_pkg::rob_depth_default,
  parameter int NUM_RT = rob_pkg::num_rt_default,
  parameter int NUM_PU = rob_pkg::num_pu_default,
  parameter int DATA_WIDTH = rob_pkg::data_width_default,
  localparam int IDX_W = $clog2(ROB_DEPTH)
) (
  input wire clk,
  // result ports, already filtered by entry validity
  input wire [NUM_PU-1:0] res_we,
  input wire [NUM_PU-1:0][IDX_W-1:0] res_entry,
  input wire [NUM_PU-1:0] res_w_valid,
  input wire [NUM_PU-1:0][DATA_WIDTH-1:0] res_data,
  input wire [NUM_PU-1:0] res_vxsat,
  // read side
  input wire [IDX_W-1:0] rptr,
  input wire [NUM_RT-1:0] rt_valid,
  input wire [ROB_DEPTH-1:0] dp_done,
  output logic [NUM_RT-1:0] rt_w_valid,
  output logic [NUM_RT-1:0][DATA_WIDTH-1:0] rt_data,
  output logic [NUM_RT-1:0] rt_vxsat,
  output logic [ROB_DEPTH-1:0] dp_w_valid,
  output logic [ROB_DEPTH-1:0][DATA_WIDTH-1:0] dp_data
);

  logic w_valid_mem [ROB_DEPTH];
  logic [DATA_WIDTH-1:0] data_mem [ROB_DEPTH];
  logic vxsat_mem [ROB_DEPTH];

  // ports never share an entry in one cycle
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PU; p++) begin
      if (res_we[p]) begin
        w_valid_mem[res_entry[p]] <= res_w_valid[p];
        data_mem[res_entry[p]] <= res_data[p];
        vxsat_mem[res_entry[p]] <= res_vxsat[p];
      end
    end
  end

  // write enable only on lanes that actually retire
  for (genvar k = 0; k < NUM_RT; k++) begin : g_rt
    logic [IDX_W-1:0] slot;
    assign slot = rptr + IDX_W'(k);
    assign rt_w_valid[k] = w_valid_mem[slot] & rt_valid[k];
    assign rt_data[k] = data_mem[slot];
    assign rt_vxsat[k] = vxsat_mem[slot];
  end

  // forwarding view, dp_done is already in age order
  for (genvar a = 0; a < ROB_DEPTH; a++) begin : g_dp
    logic [IDX_W-1:0] slot;
    assign slot = rptr + IDX_W'(a);
    assign dp_w_valid[a] = w_valid_mem[slot] & dp_done[a];
    assign dp_data[a] = data_mem[slot];
  end

endmodule

`default_nettype wire

//--- verilog/rob_info_store.sv
`default_nettype none
`timescale 1ns/10ps

module rob_info_store #(
  parameter int ROB_DEPTH = rob_pkg::rob_depth_default,
  parameter int NUM_DP = rob_pkg::num_dp_default,
  parameter int NUM_RT = rob_pkg::num_rt_default,
  localparam int IDX_W = $clog2(ROB_DEPTH),
  localparam int VW = rob_pkg::vreg_idx_width
) (
  input wire clk,
  // write side, from dispatch
  input wire [NUM_DP-1:0] push_en,
  input wire [IDX_W-1:0] wptr,
  input wire [NUM_DP-1:0][VW-1:0] uop_w_index,
  input wire [NUM_DP-1:0] uop_last,
  // read side
  input wire [IDX_W-1:0] rptr,
  output logic [NUM_RT-1:0][VW-1:0] rt_w_index,
  output logic [NUM_RT-1:0] rt_last,
  output logic [ROB_DEPTH-1:0][VW-1:0] dp_w_index
);

  // destination register and last-uop flag per entry
  logic [VW-1:0] w_index_mem [ROB_DEPTH];
  logic last_mem [ROB_DEPTH];

  logic [NUM_DP-1:0][IDX_W-1:0] wr_slot;

  for (genvar k = 0; k < NUM_DP; k++) begin : g_wr
    assign wr_slot[k] = wptr + IDX_W'(k);
  end

  // lanes land on consecutive entries
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_DP; k++) begin
      if (push_en[k]) begin
        w_index_mem[wr_slot[k]] <= uop_w_index[k];
        last_mem[wr_slot[k]] <= uop_last[k];
      end
    end
  end

  // retire lanes from the oldest entry on
  for (genvar k = 0; k < NUM_RT; k++) begin : g_rt
    logic [IDX_W-1:0] slot;
    assign slot = rptr + IDX_W'(k);
    assign rt_w_index[k] = w_index_mem[slot];
    assign rt_last[k] = last_mem[slot];
  end

  // whole buffer in age order for operand forwarding
  for (genvar a = 0; a < ROB_DEPTH; a++) begin : g_dp
    logic [IDX_W-1:0] slot;
    assign slot = rptr + IDX_W'(a);
    assign dp_w_index[a] = w_index_mem[slot];
  end

endmodule

`default_nettype wire

//--- verilog/rob_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module rob_ctrl #(
  parameter int ROB_DEPTH = rob_pkg::rob_depth_default,
  parameter int NUM_DP = rob_pkg::num_dp_default,
  parameter int NUM_RT = rob_pkg::num_rt_default,
  parameter int NUM_PU = rob_pkg::num_pu_default,
  localparam int IDX_W = $clog2(ROB_DEPTH)
) (
  input wire clk,
  input wire rst_n,
  // dispatch side
  input wire [NUM_DP-1:0] uop_valid,
  output logic [NUM_DP-1:0] uop_ready,
  output logic [IDX_W-1:0] uop_index,
  // result ports
  input wire [NUM_PU-1:0] res_valid,
  input wire [NUM_PU-1:0][IDX_W-1:0] res_entry,
  // trap report
  input wire trap_valid,
  input wire [IDX_W-1:0] trap_entry,
  // retire side
  input wire [NUM_RT-1:0] rt_ready,
  output logic [NUM_RT-1:0] rt_valid,
  output logic [NUM_RT-1:0] rt_trap,
  // store control
  output logic [NUM_DP-1:0] push_en,
  output logic [IDX_W-1:0] wptr,
  output logic [IDX_W-1:0] rptr,
  output logic [NUM_PU-1:0] res_we,
  // dispatch view, oldest first
  output logic [ROB_DEPTH-1:0] dp_entry_valid,
  output logic [ROB_DEPTH-1:0] dp_done
);

  localparam int CNT_W = IDX_W + 1;

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] free_cnt;
  logic [CNT_W-1:0] push_cnt;
  logic [CNT_W-1:0] pop_cnt;
  logic [ROB_DEPTH-1:0] entry_valid;
  logic [ROB_DEPTH-1:0] entry_done;
  logic [ROB_DEPTH-1:0] entry_trap;
  logic [NUM_DP-1:0][IDX_W-1:0] push_ptr;
  logic [NUM_RT-1:0][IDX_W-1:0] rt_ptr;
  logic [NUM_RT-1:0] pop;
  logic flush;

  assign uop_index = wptr;
  assign free_cnt = CNT_W'(ROB_DEPTH) - count;

  // lane k needs k+1 free entries
  for (genvar k = 0; k < NUM_DP; k++) begin : g_dp
    assign uop_ready[k] = free_cnt > CNT_W'(k);
    assign push_ptr[k] = wptr + IDX_W'(k);
  end

  // accepted lanes, kept as a prefix
  always_comb begin : p_push
    logic chain;
    chain = 1'b1;
    for (int k = 0; k < NUM_DP; k++) begin
      push_en[k] = chain & uop_valid[k] & uop_ready[k];
      chain = push_en[k];
    end
  end

  // results only land on live entries
  for (genvar p = 0; p < NUM_PU; p++) begin : g_res
    assign res_we[p] = res_valid[p] & entry_valid[res_entry[p]];
  end

  for (genvar k = 0; k < NUM_RT; k++) begin : g_rt
    assign rt_ptr[k] = rptr + IDX_W'(k);
    assign rt_trap[k] = entry_trap[rt_ptr[k]];
    assign pop[k] = rt_valid[k] & rt_ready[k];
  end

  // in-order retire, nothing passes a trapped lane
  always_comb begin : p_retire
    logic chain;
    chain = 1'b1;
    for (int k = 0; k < NUM_RT; k++) begin
      rt_valid[k] = chain & entry_valid[rt_ptr[k]] & entry_done[rt_ptr[k]];
      chain = rt_valid[k] & ~entry_trap[rt_ptr[k]];
    end
  end

  assign flush = |(pop & rt_trap);

  always_comb begin
    push_cnt = '0;
    pop_cnt = '0;
    for (int k = 0; k < NUM_DP; k++) begin
      push_cnt = push_cnt + CNT_W'(push_en[k]);
    end
    for (int k = 0; k < NUM_RT; k++) begin
      pop_cnt = pop_cnt + CNT_W'(pop[k]);
    end
  end

  // pointers and occupancy
  // a flush drops same-cycle pushes and keeps wptr where it was
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr <= '0;
      rptr <= '0;
      count <= '0;
    end else if (flush) begin
      rptr <= wptr;
      count <= '0;
    end else begin
      wptr <= wptr + IDX_W'(push_cnt);
      rptr <= rptr + IDX_W'(pop_cnt);
      count <= count + push_cnt - pop_cnt;
    end
  end

  // per-entry flags
  // pop clears last so it wins over a late result on the same entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      entry_valid <= '0;
      entry_done <= '0;
      entry_trap <= '0;
    end else if (flush) begin
      entry_valid <= '0;
      entry_done <= '0;
      entry_trap <= '0;
    end else begin
      for (int p = 0; p < NUM_PU; p++) begin
        if (res_we[p]) begin
          entry_done[res_entry[p]] <= 1'b1;
        end
      end
      if (trap_valid && entry_valid[trap_entry]) begin
        entry_trap[trap_entry] <= 1'b1;
      end
      for (int k = 0; k < NUM_RT; k++) begin
        if (pop[k]) begin
          entry_valid[rt_ptr[k]] <= 1'b0;
          entry_done[rt_ptr[k]] <= 1'b0;
          entry_trap[rt_ptr[k]] <= 1'b0;
        end
      end
      for (int k = 0; k < NUM_DP; k++) begin
        if (push_en[k]) begin
          entry_valid[push_ptr[k]] <= 1'b1;
        end
      end
    end
  end

  // rotate flags into age order
  for (genvar a = 0; a < ROB_DEPTH; a++) begin : g_view
    logic [IDX_W-1:0] slot;
    assign slot = rptr + IDX_W'(a);
    assign dp_entry_valid[a] = entry_valid[slot];
    assign dp_done[a] = entry_done[slot];
  end

endmodule

`default_nettype wire

//--- verilog/rob_pkg.sv
`default_nettype none

// shared sizes of the vector back end reorder buffer
package rob_pkg;

  // number of buffer entries, must stay a power of two
  localparam int rob_depth_default = 8;

  // index width that goes with the default depth
  localparam int rob_idx_width_default = $clog2(rob_depth_default);

  // uops accepted from dispatch per cycle
  localparam int num_dp_default = 2;

  // uops handed to the retire unit per cycle
  localparam int num_rt_default = 2;

  // processing unit result ports
  localparam int num_pu_default = 3;

  // result payload width
  localparam int data_width_default = 32;

  // 32 vector registers
  localparam int vreg_idx_width = 5;

endpackage

`default_nettype wire
